// ==== hw/osd_consts.svh ====
// OSD controller constants for command codes, register selects, window, version and defaults
`ifndef OSD_CONSTS_SVH
`define OSD_CONSTS_SVH

// ------------------------------
// command codes {read, group, kind}
// ------------------------------
`define OSD_CMD_RESET_CTRL    6'b0_000_10
`define OSD_CMD_OSD_CTRL      6'b0_010_10
`define OSD_CMD_CHIP_CFG      6'b0_000_01
`define OSD_CMD_CPU_CFG       6'b0_001_01
`define OSD_CMD_MEMORY_CFG    6'b0_010_01
`define OSD_CMD_VIDEO_CFG     6'b0_011_01
`define OSD_CMD_FLOPPY_CFG    6'b0_100_01
`define OSD_CMD_HARDDISK_CFG  6'b0_101_01
`define OSD_CMD_JOYSTICK_CFG  6'b0_110_01
`define OSD_CMD_OSD_BUFFER    6'b0_000_11
`define OSD_CMD_VERSION       6'b1_000_10

// settings register selects
`define OSD_REG_RESET_CTRL    4'd0
`define OSD_REG_OSD_CTRL      4'd1
`define OSD_REG_CHIP_CFG      4'd2
`define OSD_REG_CPU_CFG       4'd3
`define OSD_REG_MEMORY_CFG    4'd4
`define OSD_REG_VIDEO_CFG     4'd5
`define OSD_REG_FLOPPY_CFG    4'd6
`define OSD_REG_HARDDISK_CFG  4'd7
`define OSD_REG_JOYSTICK_CFG  4'd8

// ------------------------------
// osd window, inclusive beam limits
// ------------------------------
`define OSD_H_START           11'd896
`define OSD_H_END             11'd1407
`define OSD_V_START           9'd64
`define OSD_V_END             9'd127

// rtl version bytes, in read order
`define OSD_VER_BETA          8'h01
`define OSD_VER_MAJOR         8'h01
`define OSD_VER_MINOR         8'h04
`define OSD_VER_SEPARATOR     8'hff

// power-up values
`define OSD_MEMORY_DEFAULT    7'b0000101
`define OSD_HIGHLIGHT_NONE    4'b1000

`endif

// ==== hw/osd_spi_pkg.sv ====
// SPI byte view for the OSD host port, raw data or command fields
`default_nettype none

package osd_spi_pkg;

  // command byte layout
  // bit 7 read, 6:4 group, 3:2 kind, 1:0 spare
  typedef struct packed {
    logic       rd;
    logic [2:0] group;
    logic [1:0] kind;
    logic [1:0] unused;
  } spi_cmd_t;

  // same received byte, two readings
  // raw for data bytes, cmd for the first byte of a frame
  typedef union packed {
    logic [7:0] raw;
    spi_cmd_t   cmd;
  } spi_byte_u;

endpackage

`default_nettype wire

// ==== hw/osd_video_pkg.sv ====
// OSD text buffer address, counted flat or built from row and column
`default_nettype none

package osd_video_pkg;

  // 8 text rows of 256 columns
  typedef struct packed {
    logic [2:0] row;
    logic [7:0] col;
  } osd_buf_fields_t;

  // write side counts flat, video side fills the fields
  typedef union packed {
    logic [10:0]     flat;
    osd_buf_fields_t fields;
  } osd_buf_addr_u;

endpackage

`default_nettype wire

// ==== hw/osd_spi_slave.sv ====
// SPI mode 0 slave, synchronises the pins, shifts bytes in and out, flags the command byte
`default_nettype none

module osd_spi_slave (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   scs_n,
  input  logic                   sck,
  input  logic                   sdi,
  output logic                   sdo,
  input  logic [7:0]             read_byte,
  output osd_spi_pkg::spi_byte_u rx_byte,
  output logic                   rx,
  output logic                   cmd
);

  logic [1:0] scs_sync;
  logic [1:0] sck_sync;
  logic [1:0] sdi_sync;
  logic       scs_d;
  logic       sck_d;
  logic       sck_rise;
  logic       sck_fall;
  logic       scs_fall;
  logic [2:0] bit_cnt;
  logic [6:0] rx_shift;
  logic [7:0] tx_shift;
  logic       first;
  logic       load;

  // ------------------------------
  // pin synchronisers
  // ------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      scs_sync <= 2'b11;
      sck_sync <= 2'b00;
      sdi_sync <= 2'b00;
      scs_d    <= 1'b1;
      sck_d    <= 1'b0;
    end else begin
      scs_sync <= {scs_sync[0], scs_n};
      sck_sync <= {sck_sync[0], sck};
      sdi_sync <= {sdi_sync[0], sdi};
      scs_d    <= scs_sync[1];
      sck_d    <= sck_sync[1];
    end
  end

  // edges only count while selected
  assign sck_rise = sck_sync[1] && !sck_d && !scs_sync[1];
  assign sck_fall = !sck_sync[1] && sck_d && !scs_sync[1];
  assign scs_fall = scs_d && !scs_sync[1];

  // bit count, byte strobe, first-byte flag
  always_ff @(posedge clk) begin
    if (reset) begin
      bit_cnt <= 3'd0;
      first   <= 1'b1;
      rx      <= 1'b0;
      cmd     <= 1'b0;
    end else begin
      rx <= 1'b0;
      if (scs_sync[1]) begin
        bit_cnt <= 3'd0;
        first   <= 1'b1;
      end else if (sck_rise) begin
        bit_cnt <= bit_cnt + 3'd1;
        if (bit_cnt == 3'd7) begin
          rx    <= 1'b1;
          cmd   <= first;
          first <= 1'b0;
        end
      end
    end
  end

  // receive shifter, msb first
  always_ff @(posedge clk) begin
    if (sck_rise) begin
      rx_shift <= {rx_shift[5:0], sdi_sync[1]};
      if (bit_cnt == 3'd7) begin
        rx_byte.raw <= {rx_shift, sdi_sync[1]};
      end
    end
  end

  // transmit shifter
  // reload one cycle after select or a byte, once read_byte has settled
  // the fall right after bit 8 must not shift the fresh byte
  always_ff @(posedge clk) begin
    if (reset) begin
      load     <= 1'b0;
      tx_shift <= 8'd0;
    end else begin
      load <= scs_fall || rx;
      if (load) begin
        tx_shift <= read_byte;
      end else if (sck_fall && bit_cnt != 3'd0) begin
        tx_shift <= {tx_shift[6:0], 1'b0};
      end
    end
  end

  assign sdo = tx_shift[7];

endmodule

`default_nettype wire

// ==== hw/osd_cmd_decoder.sv ====
// OSD command decoder, tracks command and byte count, drives register and buffer writes
`default_nettype none
`include "osd_consts.svh"

module osd_cmd_decoder (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         rx,
  input  logic                         cmd,
  input  osd_spi_pkg::spi_byte_u       rx_byte,
  input  logic                         osd_enable,
  input  logic [7:0]                   osd_ctrl,
  output logic                         cfg_we,
  output logic [3:0]                   cfg_sel,
  output logic [7:0]                   cfg_data,
  output logic                         buf_we,
  output osd_video_pkg::osd_buf_addr_u buf_waddr,
  output logic [7:0]                   buf_wdata,
  output logic [3:0]                   highlight,
  output logic [7:0]                   read_byte
);

  logic [5:0] cmd_code;
  logic [2:0] dat_cnt;
  logic       is_cfg;
  logic       is_buf;
  logic       data_rx;
  logic       buf_setup;

  assign data_rx = rx && !cmd;

  // current command, data count saturates at 4
  always_ff @(posedge clk) begin
    if (reset) begin
      cmd_code <= 6'd0;
      dat_cnt  <= 3'd0;
    end else if (rx && cmd) begin
      cmd_code <= {rx_byte.cmd.rd, rx_byte.cmd.group, rx_byte.cmd.kind};
      dat_cnt  <= 3'd0;
    end else if (data_rx && dat_cnt != 3'd4) begin
      dat_cnt <= dat_cnt + 3'd1;
    end
  end

  // ------------------------------
  // command to register select
  // ------------------------------
  always_comb begin
    is_cfg  = 1'b1;
    is_buf  = 1'b0;
    cfg_sel = `OSD_REG_RESET_CTRL;
    case (cmd_code)
      `OSD_CMD_RESET_CTRL:   cfg_sel = `OSD_REG_RESET_CTRL;
      `OSD_CMD_OSD_CTRL:     cfg_sel = `OSD_REG_OSD_CTRL;
      `OSD_CMD_CHIP_CFG:     cfg_sel = `OSD_REG_CHIP_CFG;
      `OSD_CMD_CPU_CFG:      cfg_sel = `OSD_REG_CPU_CFG;
      `OSD_CMD_MEMORY_CFG:   cfg_sel = `OSD_REG_MEMORY_CFG;
      `OSD_CMD_VIDEO_CFG:    cfg_sel = `OSD_REG_VIDEO_CFG;
      `OSD_CMD_FLOPPY_CFG:   cfg_sel = `OSD_REG_FLOPPY_CFG;
      `OSD_CMD_HARDDISK_CFG: cfg_sel = `OSD_REG_HARDDISK_CFG;
      `OSD_CMD_JOYSTICK_CFG: cfg_sel = `OSD_REG_JOYSTICK_CFG;
      `OSD_CMD_OSD_BUFFER: begin
        is_cfg = 1'b0;
        is_buf = 1'b1;
      end
      default: is_cfg = 1'b0;
    endcase
  end

  // settings take data byte 0 only
  assign cfg_we   = data_rx && is_cfg && dat_cnt == 3'd0;
  assign cfg_data = rx_byte.raw;

  // buffer, byte 3 picks the row, bytes 4 on are text
  assign buf_setup = data_rx && is_buf && dat_cnt == 3'd3;
  assign buf_we    = data_rx && is_buf && dat_cnt == 3'd4;
  assign buf_wdata = rx_byte.raw;

  always_ff @(posedge clk) begin
    if (buf_setup) begin
      buf_waddr.fields.row <= rx_byte.raw[2:0];
      buf_waddr.fields.col <= 8'd0;
    end else if (buf_we) begin
      buf_waddr.flat <= buf_waddr.flat + 11'd1;
    end
  end

  // highlight row, bit 4 of the row byte enables the load
  always_ff @(posedge clk) begin
    if (reset || !osd_enable) begin
      highlight <= `OSD_HIGHLIGHT_NONE;
    end else if (buf_setup && rx_byte.raw[4]) begin
      highlight <= rx_byte.raw[3:0];
    end
  end

  // ------------------------------
  // read-back byte
  // ------------------------------
  always_comb begin
    read_byte = osd_ctrl;
    if (cmd_code == `OSD_CMD_VERSION) begin
      case (dat_cnt)
        3'd0:    read_byte = `OSD_VER_BETA;
        3'd1:    read_byte = `OSD_VER_MAJOR;
        3'd2:    read_byte = `OSD_VER_MINOR;
        default: read_byte = `OSD_VER_SEPARATOR;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== hw/osd_config_regs.sv ====
// OSD settings registers, shadowed fields reach the core only during reset
`default_nettype none
`include "osd_consts.svh"

module osd_config_regs (
  input  logic       clk,
  input  logic       reset,
  input  logic       cfg_we,
  input  logic [3:0] cfg_sel,
  input  logic [7:0] cfg_data,
  output logic       cpuhlt          = 1'b1,
  output logic       cpurst          = 1'b1,
  output logic       usrrst          = 1'b0,
  output logic       key_disable     = 1'b0,
  output logic       osd_enable      = 1'b0,
  output logic [1:0] dither          = 2'd0,
  output logic [1:0] hr_filter       = 2'd0,
  output logic [1:0] lr_filter       = 2'd0,
  output logic [1:0] scanline        = 2'd0,
  output logic [6:0] memory_config   = `OSD_MEMORY_DEFAULT,
  output logic [4:0] chipset_config  = 5'd0,
  output logic [3:0] cpu_config      = 4'd0,
  output logic [3:0] floppy_config   = 4'd0,
  output logic [2:0] ide_config      = 3'd0,
  output logic [1:0] autofire_config = 2'd0
);

  // host side copies of the reset-gated settings
  logic [4:0] chipset_shadow = 5'd0;
  logic [2:0] ide_shadow     = 3'd0;
  logic [3:0] cpu_shadow     = 4'd0;
  logic [6:0] memory_shadow  = `OSD_MEMORY_DEFAULT;

  // ------------------------------
  // host writes
  // ------------------------------
  always_ff @(posedge clk) begin
    if (cfg_we) begin
      case (cfg_sel)
        `OSD_REG_RESET_CTRL:   {cpuhlt, cpurst, usrrst} <= cfg_data[2:0];
        `OSD_REG_OSD_CTRL:     {key_disable, osd_enable} <= cfg_data[1:0];
        `OSD_REG_CHIP_CFG:     chipset_shadow <= cfg_data[4:0];
        `OSD_REG_CPU_CFG:      cpu_shadow <= cfg_data[3:0];
        `OSD_REG_MEMORY_CFG:   memory_shadow <= cfg_data[6:0];
        `OSD_REG_VIDEO_CFG:    {dither, hr_filter, lr_filter, scanline} <= cfg_data;
        `OSD_REG_FLOPPY_CFG:   floppy_config <= cfg_data[3:0];
        `OSD_REG_HARDDISK_CFG: ide_shadow <= cfg_data[2:0];
        `OSD_REG_JOYSTICK_CFG: autofire_config <= cfg_data[1:0];
        default: begin
        end
      endcase
    end
  end

  // chipset, disks, cpu type and memory sizes change only in reset
  // cache, kickstart and hrtmon bits follow at once
  always_ff @(posedge clk) begin
    if (reset) begin
      chipset_config     <= chipset_shadow;
      ide_config         <= ide_shadow;
      cpu_config[1:0]    <= cpu_shadow[1:0];
      memory_config[5:0] <= memory_shadow[5:0];
    end
    cpu_config[3:2]  <= cpu_shadow[3:2];
    memory_config[6] <= memory_shadow[6];
  end

endmodule

`default_nettype wire

// ==== hw/osd_buffer.sv ====
// OSD text bitmap buffer, 2048 bytes, one write port and one registered read port
`default_nettype none

module osd_buffer (
  input  logic                         clk,
  input  logic                         we,
  input  osd_video_pkg::osd_buf_addr_u waddr,
  input  logic [7:0]                   wdata,
  input  osd_video_pkg::osd_buf_addr_u raddr,
  output logic [7:0]                   rdata
);

  // single block ram
  logic [7:0] mem [0:2047];

  // host side
  always_ff @(posedge clk) begin
    if (we) begin
      mem[waddr.flat] <= wdata;
    end
  end

  // video side, data one clk after the address
  always_ff @(posedge clk) begin
    rdata <= mem[raddr.flat];
  end

endmodule

`default_nettype wire

// ==== hw/osd_video.sv ====
// OSD overlay generator, beam counters, window, highlight and pixel output
`default_nettype none
`include "osd_consts.svh"

module osd_video (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         sol,
  input  logic                         sof,
  input  logic                         osd_enable,
  input  logic [3:0]                   highlight,
  output osd_video_pkg::osd_buf_addr_u buf_raddr,
  input  logic [7:0]                   buf_rdata,
  output logic                         osd_blank,
  output logic                         osd_pixel
);

  logic [10:0] horbeam;
  logic [10:0] hor_next;
  logic [10:0] hor_off;
  logic [8:0]  verbeam;
  logic [8:0]  ver_next;
  logic        osd_enabled;
  logic        in_window;
  logic        invert;

  // ------------------------------
  // beam counters
  // ------------------------------
  // next state also feeds the buffer address
  always_comb begin
    hor_next = horbeam + 11'd1;
    ver_next = verbeam;
    if (reset || sol) begin
      hor_next = 11'd0;
    end
    if (reset || sof) begin
      ver_next = 9'd0;
    end else if (sol) begin
      ver_next = verbeam + 9'd1;
    end
  end

  always_ff @(posedge clk) begin
    horbeam <= hor_next;
    verbeam <= ver_next;
  end

  // enable only changes at frame start
  always_ff @(posedge clk) begin
    if (reset) begin
      osd_enabled <= 1'b0;
    end else if (sof) begin
      osd_enabled <= osd_enable;
    end
  end

  // address one beam step ahead, ram data lines up with horbeam
  // two pixels per column
  assign hor_off = hor_next - `OSD_H_START;

  always_comb begin
    buf_raddr.fields.row = ver_next[5:3];
    buf_raddr.fields.col = hor_off[8:1];
  end

  // ------------------------------
  // window and pixel
  // ------------------------------
  assign in_window = osd_enabled &&
                     horbeam >= `OSD_H_START && horbeam <= `OSD_H_END &&
                     verbeam >= `OSD_V_START && verbeam <= `OSD_V_END;

  // highlight[3] set means no row highlighted
  assign invert = !highlight[3] && verbeam[5:3] == highlight[2:0];

  always_ff @(posedge clk) begin
    if (reset) begin
      osd_blank <= 1'b0;
      osd_pixel <= 1'b0;
    end else begin
      osd_blank <= in_window;
      osd_pixel <= in_window && (buf_rdata[verbeam[2:0]] ^ invert);
    end
  end

endmodule

`default_nettype wire

// ==== hw/osd_controller.sv ====
// OSD controller top, SPI host port, settings, text buffer and video overlay
`default_nettype none

module osd_controller (
  input  logic       clk,
  input  logic       reset,
  input  logic       sol,
  input  logic       sof,
  input  logic [7:0] osd_ctrl,
  input  logic       scs_n,
  input  logic       sck,
  input  logic       sdi,
  output logic       sdo,
  output logic       osd_blank,
  output logic       osd_pixel,
  output logic       cpuhlt,
  output logic       cpurst,
  output logic       usrrst,
  output logic       key_disable,
  output logic       osd_enable,
  output logic [1:0] dither,
  output logic [1:0] hr_filter,
  output logic [1:0] lr_filter,
  output logic [1:0] scanline,
  output logic [6:0] memory_config,
  output logic [4:0] chipset_config,
  output logic [3:0] cpu_config,
  output logic [3:0] floppy_config,
  output logic [2:0] ide_config,
  output logic [1:0] autofire_config
);

  osd_spi_pkg::spi_byte_u       rx_byte;
  logic                         rx;
  logic                         cmd;
  logic [7:0]                   read_byte;
  logic                         cfg_we;
  logic [3:0]                   cfg_sel;
  logic [7:0]                   cfg_data;
  logic                         buf_we;
  osd_video_pkg::osd_buf_addr_u buf_waddr;
  logic [7:0]                   buf_wdata;
  osd_video_pkg::osd_buf_addr_u buf_raddr;
  logic [7:0]                   buf_rdata;
  logic [3:0]                   highlight;

  // ------------------------------
  // host port
  // ------------------------------
  osd_spi_slave u_spi (
    .clk       (clk),
    .reset     (reset),
    .scs_n     (scs_n),
    .sck       (sck),
    .sdi       (sdi),
    .sdo       (sdo),
    .read_byte (read_byte),
    .rx_byte   (rx_byte),
    .rx        (rx),
    .cmd       (cmd)
  );

  osd_cmd_decoder u_decoder (
    .clk        (clk),
    .reset      (reset),
    .rx         (rx),
    .cmd        (cmd),
    .rx_byte    (rx_byte),
    .osd_enable (osd_enable),
    .osd_ctrl   (osd_ctrl),
    .cfg_we     (cfg_we),
    .cfg_sel    (cfg_sel),
    .cfg_data   (cfg_data),
    .buf_we     (buf_we),
    .buf_waddr  (buf_waddr),
    .buf_wdata  (buf_wdata),
    .highlight  (highlight),
    .read_byte  (read_byte)
  );

  osd_config_regs u_regs (
    .clk             (clk),
    .reset           (reset),
    .cfg_we          (cfg_we),
    .cfg_sel         (cfg_sel),
    .cfg_data        (cfg_data),
    .cpuhlt          (cpuhlt),
    .cpurst          (cpurst),
    .usrrst          (usrrst),
    .key_disable     (key_disable),
    .osd_enable      (osd_enable),
    .dither          (dither),
    .hr_filter       (hr_filter),
    .lr_filter       (lr_filter),
    .scanline        (scanline),
    .memory_config   (memory_config),
    .chipset_config  (chipset_config),
    .cpu_config      (cpu_config),
    .floppy_config   (floppy_config),
    .ide_config      (ide_config),
    .autofire_config (autofire_config)
  );

  // ------------------------------
  // overlay path
  // ------------------------------
  osd_buffer u_buffer (
    .clk   (clk),
    .we    (buf_we),
    .waddr (buf_waddr),
    .wdata (buf_wdata),
    .raddr (buf_raddr),
    .rdata (buf_rdata)
  );

  osd_video u_video (
    .clk        (clk),
    .reset      (reset),
    .sol        (sol),
    .sof        (sof),
    .osd_enable (osd_enable),
    .highlight  (highlight),
    .buf_raddr  (buf_raddr),
    .buf_rdata  (buf_rdata),
    .osd_blank  (osd_blank),
    .osd_pixel  (osd_pixel)
  );

endmodule

`default_nettype wire

// ==== tests/osd_controller_tb.sv ====
// testbench for the OSD controller, SPI host, settings, version read and overlay checks
`default_nettype none
`include "osd_consts.svh"

module osd_controller_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int    LINE_LEN        = 1440;
  localparam int    FRAME_LINES     = 136;
  localparam longint FRAME_CLKS     = LINE_LEN * FRAME_LINES;
  localparam longint SPI_BYTE_CLKS  = 8 * 8 + 4;
  localparam longint SPI_BYTES      = 2200;
  // video frames checked plus all spi traffic, doubled for margin
  localparam longint TIMEOUT_CLKS   = 6 * FRAME_CLKS + 2 * SPI_BYTES * SPI_BYTE_CLKS;

  logic clk = 1'b0;
  logic reset, sol, sof, scs_n, sck, sdi;
  logic [7:0] osd_ctrl;
  logic sdo, osd_blank, osd_pixel, cpuhlt, cpurst, usrrst, key_disable, osd_enable;
  logic [1:0] dither, hr_filter, lr_filter, scanline, autofire_config;
  logic [6:0] memory_config;
  logic [4:0] chipset_config;
  logic [3:0] cpu_config, floppy_config;
  logic [2:0] ide_config;

  logic [31:0] lfsr_state = 32'h672efcb9;
  logic [7:0]  tx_q[$];
  logic [7:0]  rx_q[$];
  logic [7:0]  exp_mem [0:2047];
  logic        exp_osd_en = 1'b0;
  logic [3:0]  exp_hl = `OSD_HIGHLIGHT_NONE;
  logic        video_check = 1'b0;
  int          blank_hits = 0;
  int          pixel_ones = 0;
  int          gen_h = 0;
  int          gen_v = 0;

  // tb beam model
  logic [10:0] m_h;
  logic [8:0]  m_v;
  logic        m_en;
  logic        exp_blank;
  logic        exp_pixel;
  logic        in_win;
  logic        inv;
  logic [10:0] hoff;
  logic [7:0]  cur_byte;

  osd_controller DUT (
    .clk(clk), .reset(reset), .sol(sol), .sof(sof), .osd_ctrl(osd_ctrl),
    .scs_n(scs_n), .sck(sck), .sdi(sdi), .sdo(sdo),
    .osd_blank(osd_blank), .osd_pixel(osd_pixel),
    .cpuhlt(cpuhlt), .cpurst(cpurst), .usrrst(usrrst),
    .key_disable(key_disable), .osd_enable(osd_enable),
    .dither(dither), .hr_filter(hr_filter), .lr_filter(lr_filter), .scanline(scanline),
    .memory_config(memory_config), .chipset_config(chipset_config),
    .cpu_config(cpu_config), .floppy_config(floppy_config),
    .ide_config(ide_config), .autofire_config(autofire_config)
  );

  always #20 clk = ~clk;

  // ------------------------------
  // helpers
  // ------------------------------
  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (exp === act) else begin
      $display("[FAIL] %s expected %h got %h", name, exp, act);
      $display("TESTBENCH FAILED");
      $fatal(1);
    end
  endtask

  // galois lfsr, one step per bit
  function automatic logic [7:0] rand_byte();
    logic [7:0] val;
    logic       b;
    val = 8'd0;
    for (int i = 0; i < 8; i++) begin
      b = lfsr_state[0];
      lfsr_state = (lfsr_state >> 1) ^ (b ? 32'h80200003 : 32'h0);
      val = {val[6:0], b};
    end
    return val;
  endfunction

  // n edges, then the 2 ns drive offset
  task automatic step_clk(input int n);
    repeat (n) @(posedge clk);
    #2;
  endtask

  // mode 0, msb first, 4 clk per sck half
  task automatic spi_byte(input logic [7:0] tx, output logic [7:0] got);
    for (int i = 7; i >= 0; i--) begin
      sdi = tx[i];
      step_clk(4);
      got[i] = sdo;
      sck = 1'b1;
      step_clk(4);
      sck = 1'b0;
    end
    step_clk(4);
  endtask

  // command byte, then every byte of tx_q
  task automatic spi_frame(input logic [5:0] code);
    logic [7:0] got;
    rx_q.delete();
    scs_n = 1'b0;
    step_clk(6);
    spi_byte({code, 2'b00}, got);
    for (int i = 0; i < tx_q.size(); i++) begin
      spi_byte(tx_q[i], got);
      rx_q.push_back(got);
    end
    step_clk(2);
    scs_n = 1'b1;
    step_clk(6);
  endtask

  task automatic write_reg(input logic [5:0] code, input logic [7:0] b);
    tx_q.delete();
    tx_q.push_back(b);
    spi_frame(code);
  endtask

  task automatic wait_frame_start();
    @(posedge clk);
    while (sof !== 1'b1) @(posedge clk);
    #2;
  endtask

  // ------------------------------
  // line and frame strobes
  // ------------------------------
  always @(posedge clk) begin
    #2;
    if (gen_h == LINE_LEN - 1) begin
      gen_h = 0;
      sol = 1'b1;
      sof = (gen_v == FRAME_LINES - 1);
      gen_v = sof ? 0 : gen_v + 1;
    end else begin
      gen_h = gen_h + 1;
      sol = 1'b0;
      sof = 1'b0;
    end
  end

  // expected overlay from window ranges and written text
  assign in_win = m_en && m_h >= `OSD_H_START && m_h <= `OSD_H_END &&
                  m_v >= `OSD_V_START && m_v <= `OSD_V_END;
  assign inv = !exp_hl[3] && m_v[5:3] == exp_hl[2:0];
  assign hoff = m_h - `OSD_H_START;
  assign cur_byte = exp_mem[{m_v[5:3], hoff[8:1]}];

  always @(posedge clk) begin
    if (reset) begin
      m_h <= 11'd0;
      m_v <= 9'd0;
      m_en <= 1'b0;
      exp_blank <= 1'b0;
      exp_pixel <= 1'b0;
    end else begin
      exp_blank <= in_win;
      exp_pixel <= in_win && (cur_byte[m_v[2:0]] ^ inv);
      m_h <= sol ? 11'd0 : m_h + 11'd1;
      if (sof) begin
        m_v <= 9'd0;
        m_en <= exp_osd_en;
      end else if (sol) begin
        m_v <= m_v + 9'd1;
      end
    end
  end

  // outputs settled mid-cycle
  always @(negedge clk) begin
    if (video_check) begin
      check_value("osd_blank", 32'(exp_blank), 32'(osd_blank));
      check_value("osd_pixel", 32'(exp_pixel), 32'(osd_pixel));
      if (osd_blank) blank_hits++;
      if (osd_pixel) pixel_ones++;
    end
  end

  initial begin
    #(TIMEOUT_CLKS * 40);
    $display("watchdog expired, the run hung");
    $display("TESTBENCH FAILED");
    $fatal(1);
  end

  // ------------------------------
  // stimulus
  // ------------------------------
  initial begin
    logic [7:0] b, c, d, p, m;
    reset = 1'b1;
    sol = 1'b0;
    sof = 1'b0;
    scs_n = 1'b1;
    sck = 1'b0;
    sdi = 1'b0;
    osd_ctrl = rand_byte();
    step_clk(5);
    reset = 1'b0;
    step_clk(4);

    // direct settings
    for (int k = 0; k < 4; k++) begin
      b = rand_byte();
      write_reg(`OSD_CMD_VIDEO_CFG, b);
      check_value("dither", 32'(b[7:6]), 32'(dither));
      check_value("hr_filter", 32'(b[5:4]), 32'(hr_filter));
      check_value("lr_filter", 32'(b[3:2]), 32'(lr_filter));
      check_value("scanline", 32'(b[1:0]), 32'(scanline));
      b = rand_byte();
      write_reg(`OSD_CMD_FLOPPY_CFG, b);
      check_value("floppy_config", 32'(b[3:0]), 32'(floppy_config));
      b = rand_byte();
      write_reg(`OSD_CMD_JOYSTICK_CFG, b);
      check_value("autofire_config", 32'(b[1:0]), 32'(autofire_config));
      b = rand_byte();
      write_reg(`OSD_CMD_OSD_CTRL, b);
      exp_osd_en = b[0];
      check_value("key_disable", 32'(b[1]), 32'(key_disable));
      check_value("osd_enable", 32'(b[0]), 32'(osd_enable));
      b = rand_byte();
      write_reg(`OSD_CMD_RESET_CTRL, b);
      check_value("cpuhlt", 32'(b[2]), 32'(cpuhlt));
      check_value("cpurst", 32'(b[1]), 32'(cpurst));
      check_value("usrrst", 32'(b[0]), 32'(usrrst));
    end

    // shadowed settings, held until a reset
    c = rand_byte();
    d = rand_byte();
    p = rand_byte();
    m = rand_byte();
    write_reg(`OSD_CMD_CHIP_CFG, c);
    write_reg(`OSD_CMD_HARDDISK_CFG, d);
    write_reg(`OSD_CMD_CPU_CFG, p);
    write_reg(`OSD_CMD_MEMORY_CFG, m);
    check_value("chipset_config", 32'h0, 32'(chipset_config));
    check_value("ide_config", 32'h0, 32'(ide_config));
    check_value("cpu_config", 32'({p[3:2], 2'b00}), 32'(cpu_config));
    check_value("memory_config", 32'({m[6], 6'b000101}), 32'(memory_config));
    reset = 1'b1;
    step_clk(3);
    reset = 1'b0;
    exp_hl = `OSD_HIGHLIGHT_NONE;
    step_clk(2);
    check_value("chipset_config", 32'(c[4:0]), 32'(chipset_config));
    check_value("ide_config", 32'(d[2:0]), 32'(ide_config));
    check_value("cpu_config", 32'(p[3:0]), 32'(cpu_config));
    check_value("memory_config", 32'(m[6:0]), 32'(memory_config));

    // version read, then plain status read
    tx_q.delete();
    repeat (4) tx_q.push_back(rand_byte());
    spi_frame(`OSD_CMD_VERSION);
    check_value("ver_beta", 32'(`OSD_VER_BETA), 32'(rx_q[0]));
    check_value("ver_major", 32'(`OSD_VER_MAJOR), 32'(rx_q[1]));
    check_value("ver_minor", 32'(`OSD_VER_MINOR), 32'(rx_q[2]));
    check_value("ver_separator", 32'(`OSD_VER_SEPARATOR), 32'(rx_q[3]));
    tx_q.delete();
    tx_q.push_back(rand_byte());
    tx_q.push_back(rand_byte());
    spi_frame(`OSD_CMD_FLOPPY_CFG);
    check_value("floppy_config", 32'(tx_q[0][3:0]), 32'(floppy_config));
    check_value("read_byte", 32'(osd_ctrl), 32'(rx_q[0]));
    check_value("read_byte", 32'(osd_ctrl), 32'(rx_q[1]));

    // enable, then fill all 8 rows, highlight on row 2
    write_reg(`OSD_CMD_OSD_CTRL, 8'h01);
    exp_osd_en = 1'b1;
    for (int r = 0; r < 8; r++) begin
      tx_q.delete();
      repeat (3) tx_q.push_back(8'h00);
      tx_q.push_back(r == 2 ? 8'h12 : 8'(r));
      for (int col = 0; col < 256; col++) begin
        b = rand_byte();
        exp_mem[r * 256 + col] = b;
        tx_q.push_back(b);
      end
      spi_frame(`OSD_CMD_OSD_BUFFER);
      if (r == 2) exp_hl = 4'd2;
    end

    // two frames with the overlay on
    wait_frame_start();
    video_check = 1'b1;
    repeat (2) wait_frame_start();
    video_check = 1'b0;

    // overlay off for a whole frame
    write_reg(`OSD_CMD_OSD_CTRL, 8'h00);
    exp_osd_en = 1'b0;
    exp_hl = `OSD_HIGHLIGHT_NONE;
    wait_frame_start();
    video_check = 1'b1;
    wait_frame_start();
    video_check = 1'b0;

    if (blank_hits == 0 || pixel_ones == 0) begin
      $display("overlay window never produced blank or pixel output");
      $display("TESTBENCH FAILED");
      $fatal(1);
    end else begin
      $display("TESTBENCH PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+hw
hw/osd_spi_pkg.sv
hw/osd_video_pkg.sv
hw/osd_spi_slave.sv
hw/osd_cmd_decoder.sv
hw/osd_config_regs.sv
hw/osd_buffer.sv
hw/osd_video.sv
hw/osd_controller.sv
tests/osd_controller_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the OSD controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -f sim.log

( verilator --binary --timing --top-module osd_controller_tb -f build.f -o osd_sim \
    && ./obj_dir/osd_sim ) > sim.log 2>&1 \
  || echo "build or simulation returned an error"

cat sim.log

grep -q "TESTBENCH PASSED" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed, see sim.log"; exit 1; }
